//--- src.f
logic/core_pkg.sv
logic/core_alu.sv
logic/core_regfile.sv
logic/core_dmem_wait_timer.sv
logic/core_dmem.sv
logic/core_s2_control.sv
logic/core_s2_top.sv
testbench/core_s2_tb.sv

//--- Bender.yml
package:
  name: core_s2

sources:
  - logic/core_pkg.sv
  - logic/core_alu.sv
  - logic/core_regfile.sv
  - logic/core_dmem_wait_timer.sv
  - logic/core_dmem.sv
  - logic/core_s2_control.sv
  - logic/core_s2_top.sv
  - target: test
    files:
      - testbench/core_s2_tb.sv

//--- testbench/core_s2_tb.sv
// --------------------------------------------------
// Stage 2 testbench, table of instructions checked
// against a model of registers and data memory
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_s2_tb;

    import core_pkg::*;

    localparam int DMEM_DEPTH   = 64;
    localparam int DMEM_LATENCY = 3;
    localparam int TIMEOUT      = 50;

    // Full 7-bit opcodes used to build the program
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_CUSTOM_0 = 7'b0001011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;

    logic  clk;
    logic  rst_n;
    word_t instruction;
    logic  instr_valid;
    logic  ready;
    logic  retire;
    wb_t   wb;
    logic  halted;

    // Stimulus table, instruction word plus expected halt
    word_t tbl_instr [$];
    bit    tbl_halt  [$];

    // Reference state of the stage
    word_t model_regs [32];
    word_t model_mem  [DMEM_DEPTH];

    int unsigned seed_value;
    int unsigned errors;
    int unsigned checks;
    int unsigned timeouts;

    core_s2_top #(
        .DMEM_DEPTH   (DMEM_DEPTH),
        .DMEM_LATENCY (DMEM_LATENCY)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .instr_valid (instr_valid),
        .ready       (ready),
        .retire      (retire),
        .wb          (wb),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Encoders for the instruction formats
    function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // Major opcodes the stage accepts, bits 6 to 2
    function automatic bit legal_opcode(input logic [4:0] opc);
        case (opc)
            5'b00000, 5'b00010, 5'b00011, 5'b00100, 5'b00101, 5'b01000, 5'b01011,
            5'b01100, 5'b01101, 5'b11000, 5'b11001, 5'b11011, 5'b11100: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // RV32I arithmetic by funct3, sub only for register forms
    function automatic word_t alu_ref(input logic [2:0] f3, input logic sub,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 'x;
        endcase
    endfunction

    // Expected retire record, then the model takes the effect
    task automatic model_step(input word_t w, output logic ill, output logic we,
                              output word_t val);
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    imm_i;
        word_t    imm_s;
        word_t    addr;
        rd    = w[11:7];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        ill   = (w[1:0] != 2'b11) || (w == 32'h0) || (w == 32'hffff_ffff)
                || !legal_opcode(w[6:2]);
        we    = 1'b0;
        val   = '0;
        if (!ill) begin
            case (w[6:0])
                OPC_OP: begin
                    val = alu_ref(w[14:12], w[30], a, b);
                    we  = 1'b1;
                end
                OPC_OP_IMM: begin
                    val = alu_ref(w[14:12], 1'b0, a, imm_i);
                    we  = 1'b1;
                end
                OPC_LUI: begin
                    val = {w[31:12], 12'h000};
                    we  = 1'b1;
                end
                OPC_LOAD: begin
                    addr = a + imm_i;
                    val  = model_mem[addr[31:2] % DMEM_DEPTH];
                    we   = 1'b1;
                end
                OPC_STORE: begin
                    addr = a + imm_s;
                    model_mem[addr[31:2] % DMEM_DEPTH] = b;
                end
                // Recognised no-ops leave everything alone
                default: ;
            endcase
            if (rd == 5'd0) begin
                we = 1'b0;
            end
            if (we) begin
                model_regs[rd] = val;
            end
        end
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic add_entry(input word_t w, input bit halt);
        tbl_instr.push_back(w);
        tbl_halt.push_back(halt);
    endtask

    task automatic build_table();
        word_t rnd;
        // Random operands in x1 to x3 through LUI then ADDI
        for (int r = 1; r <= 3; r++) begin
            rnd = $urandom;
            add_entry(u_type(rnd[31:12], reg_idx_t'(r), OPC_LUI), 1'b0);
            rnd = $urandom;
            add_entry(i_type(rnd[11:0], reg_idx_t'(r), 3'b000, reg_idx_t'(r), OPC_OP_IMM), 1'b0);
        end
        // Register forms, x3 doubles as shift amount
        add_entry(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 1'b0);
        add_entry(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd5), 1'b0);
        add_entry(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd6), 1'b0);
        add_entry(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd7), 1'b0);
        add_entry(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), 1'b0);
        add_entry(r_type(7'h00, 5'd3, 5'd1, 3'b001, 5'd9), 1'b0);
        add_entry(r_type(7'h00, 5'd3, 5'd1, 3'b101, 5'd10), 1'b0);
        add_entry(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd11), 1'b0);
        add_entry(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd12), 1'b0);
        // Immediate forms
        rnd = $urandom;
        add_entry(i_type(rnd[11:0], 5'd1, 3'b111, 5'd13, OPC_OP_IMM), 1'b0);
        add_entry(i_type(rnd[23:12], 5'd2, 3'b110, 5'd14, OPC_OP_IMM), 1'b0);
        rnd = $urandom;
        add_entry(i_type(rnd[11:0], 5'd3, 3'b100, 5'd15, OPC_OP_IMM), 1'b0);
        add_entry(i_type({7'h00, rnd[16:12]}, 5'd1, 3'b001, 5'd16, OPC_OP_IMM), 1'b0);
        add_entry(i_type({7'h00, rnd[21:17]}, 5'd2, 3'b101, 5'd17, OPC_OP_IMM), 1'b0);
        add_entry(i_type(rnd[31:20], 5'd1, 3'b010, 5'd18, OPC_OP_IMM), 1'b0);
        // Stores and loads around base x20 = 16, negative offset too
        add_entry(i_type(12'd16, 5'd0, 3'b000, 5'd20, OPC_OP_IMM), 1'b0);
        add_entry(s_type(12'd0, 5'd1, 5'd20), 1'b0);
        add_entry(s_type(12'd4, 5'd2, 5'd20), 1'b0);
        add_entry(i_type(12'd0, 5'd20, 3'b010, 5'd21, OPC_LOAD), 1'b0);
        add_entry(i_type(12'd4, 5'd20, 3'b010, 5'd22, OPC_LOAD), 1'b0);
        add_entry(s_type(12'hffc, 5'd4, 5'd20), 1'b0);
        add_entry(i_type(12'hffc, 5'd20, 3'b010, 5'd23, OPC_LOAD), 1'b0);
        add_entry(i_type(12'd0, 5'd20, 3'b010, 5'd24, OPC_LOAD), 1'b0);
        // Writes to x0 are dropped, then x0 read back
        add_entry(i_type(12'd77, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 1'b0);
        add_entry(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 1'b0);
        add_entry(i_type(12'd0, 5'd20, 3'b010, 5'd0, OPC_LOAD), 1'b0);
        add_entry(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd25), 1'b0);
        // Illegal words, then legal no-ops, all aimed at x26
        add_entry(32'h0000_0000, 1'b0);
        add_entry(32'hffff_ffff, 1'b0);
        add_entry(i_type(12'd5, 5'd0, 3'b000, 5'd26, OPC_OP_IMM) & ~32'h1, 1'b0);
        add_entry(i_type(12'd5, 5'd0, 3'b000, 5'd26, 7'b1010111), 1'b0);
        add_entry(u_type(20'h12345, 5'd26, OPC_AUIPC), 1'b0);
        add_entry(u_type(20'h00100, 5'd26, OPC_JAL), 1'b0);
        add_entry(r_type(7'h00, 5'd0, 5'd26, 3'b000, 5'd27), 1'b0);
        add_entry({25'h0, OPC_CUSTOM_0}, 1'b1);
    endtask

    task automatic wait_ready(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = ready;
        end
        if (!seen) begin
            $display("Timeout at %0t: ready did not rise within %0d cycles", $time, TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic wait_result(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = retire || halted;
        end
        if (!seen) begin
            $display("Timeout at %0t: no retire and no halt within %0d cycles", $time, TIMEOUT);
            timeouts++;
        end
    endtask

    // One-cycle strobe, the word stays on the bus afterwards
    task automatic apply_instr(input word_t w);
        @(posedge clk);
        instruction <= w;
        instr_valid <= 1'b1;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    initial begin
        word_t rnd;
        logic  exp_ill;
        logic  exp_we;
        word_t exp_val;
        bit    seen;
        seed_value  = 32'h2e76f674;
        rnd         = $urandom(seed_value);
        errors      = 0;
        checks      = 0;
        timeouts    = 0;
        rst_n       = 1'b0;
        instruction = '0;
        instr_valid = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int m = 0; m < DMEM_DEPTH; m++) begin
            model_mem[m] = '0;
        end
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // Quiet outputs while still in INIT
        @(negedge clk);
        check_value("ready", ready, 1'b0);
        check_value("retire", retire, 1'b0);
        check_value("halted", halted, 1'b0);
        for (int i = 0; i < tbl_instr.size(); i++) begin
            wait_ready(seen);
            if (!seen) break;
            check_value("retire", retire, 1'b0);
            apply_instr(tbl_instr[i]);
            wait_result(seen);
            if (!seen) break;
            if (tbl_halt[i]) begin
                check_value("halted", halted, 1'b1);
                check_value("retire", retire, 1'b0);
            end else begin
                model_step(tbl_instr[i], exp_ill, exp_we, exp_val);
                check_value("retire", retire, 1'b1);
                check_value("wb.illegal", wb.illegal, exp_ill);
                check_value("wb.rd_we", wb.rd_we, exp_we);
                if (exp_we) begin
                    check_value("wb.rd_idx", wb.rd_idx, tbl_instr[i][11:7]);
                    check_value("wb.value", wb.value, exp_val);
                end
            end
        end
        // A halted stage ignores any further strobe
        if (timeouts == 0) begin
            apply_instr(i_type(12'd1, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
            for (int n = 0; n < TIMEOUT; n++) begin
                @(negedge clk);
                check_value("retire", retire, 1'b0);
                check_value("ready", ready, 1'b0);
                check_value("halted", halted, 1'b1);
            end
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : core_s2_tb

`default_nettype wire

//--- logic/core_s2_top.sv
// --------------------------------------------------
// Stage 2 top: control, timer, registers, ALU, RAM
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_s2_top #(
    parameter int DMEM_DEPTH   = 64,
    parameter int DMEM_LATENCY = 3
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire core_pkg::word_t instruction,
    input  wire logic            instr_valid,
    output logic                 ready,
    output logic                 retire,
    output core_pkg::wb_t        wb,
    output logic                 halted
);

    import core_pkg::*;

    // Register file side
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;

    // ALU side
    alu_op_e  alu_op;
    word_t    alu_b;
    word_t    alu_result;

    // Memory side
    logic     timer_start;
    logic     timer_done;
    word_t    dmem_addr;
    word_t    dmem_wdata;
    logic     dmem_we;
    word_t    dmem_rdata;

    core_s2_control i_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .instr_valid (instr_valid),
        .ready       (ready),
        .retire      (retire),
        .halted      (halted),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_op      (alu_op),
        .alu_b       (alu_b),
        .alu_result  (alu_result),
        .timer_start (timer_start),
        .timer_done  (timer_done),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_we     (dmem_we),
        .dmem_rdata  (dmem_rdata),
        .wb          (wb)
    );

    core_dmem_wait_timer #(
        .DMEM_LATENCY (DMEM_LATENCY)
    ) i_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .done  (timer_done)
    );

    // Write port fed by the retire record
    core_regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    core_alu i_alu (
        .a      (rs1_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    core_dmem #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) i_dmem (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .we    (dmem_we),
        .rdata (dmem_rdata)
    );

endmodule : core_s2_top

`default_nettype wire

//--- logic/core_s2_control.sv
// --------------------------------------------------
// Stage 2 control with the instruction latch, decode
// and the FSM that sequences execute, memory wait and retire
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_s2_control (
    input  wire logic               clk,
    input  wire logic               rst_n,

    // Outside instruction strobe
    input  wire core_pkg::word_t    instruction,
    input  wire logic               instr_valid,
    output logic                    ready,
    output logic                    retire,
    output logic                    halted,

    // Register file and ALU
    output core_pkg::reg_idx_t      rs1_idx,
    output core_pkg::reg_idx_t      rs2_idx,
    input  wire core_pkg::word_t    rs1_data,
    input  wire core_pkg::word_t    rs2_data,
    output core_pkg::alu_op_e       alu_op,
    output core_pkg::word_t         alu_b,
    input  wire core_pkg::word_t    alu_result,

    // Memory timer and data RAM
    output logic                    timer_start,
    input  wire logic               timer_done,
    output core_pkg::word_t         dmem_addr,
    output core_pkg::word_t         dmem_wdata,
    output logic                    dmem_we,
    input  wire core_pkg::word_t    dmem_rdata,

    // Retire record
    output core_pkg::wb_t           wb
);

    import core_pkg::*;

    typedef enum logic [2:0] {
        INIT,
        HALT,
        FETCH_NEXT,
        WAIT_ON_L1DCACHE,
        FINISH_CURRENT_AND_FETCH_NEXT
    } state_e;

    state_e  state_q;
    state_e  state_d;
    word_t   instr_q;
    decode_t dec;
    decode_t dec_in;
    logic    accept;

    // Full decode of one instruction word
    function automatic decode_t decode_word(input word_t instr);
        opcode_e    opc;
        logic [2:0] funct3;
        logic       supported;
        decode_t    d;
        opc       = opcode_e'(instr[6:2]);
        funct3    = instr[14:12];
        d         = '0;
        d.rd_idx  = instr[11:7];
        d.rs1_idx = instr[19:15];
        d.rs2_idx = instr[24:20];
        // Opcodes recognised at all whether executed or not
        case (opc)
            OPCODE_LOAD, OPCODE_CUSTOM_0, OPCODE_MISC_MEM, OPCODE_OP_IMM,
            OPCODE_AUIPC, OPCODE_STORE, OPCODE_AMO, OPCODE_OP, OPCODE_LUI,
            OPCODE_BRANCH, OPCODE_JALR, OPCODE_JAL, OPCODE_SYSTEM: supported = 1'b1;
            default:                                              supported = 1'b0;
        endcase
        d.illegal = !supported || (instr[1:0] != 2'b11) || (instr == '0) || (instr == '1);
        case (opc)
            OPCODE_OP, OPCODE_AMO:                                    d.format = INSTR_FORMAT_R;
            OPCODE_LOAD, OPCODE_MISC_MEM, OPCODE_OP_IMM, OPCODE_JALR: d.format = INSTR_FORMAT_I;
            OPCODE_STORE:                                             d.format = INSTR_FORMAT_S;
            OPCODE_BRANCH:                                            d.format = INSTR_FORMAT_B;
            OPCODE_LUI, OPCODE_AUIPC:                                 d.format = INSTR_FORMAT_U;
            OPCODE_JAL:                                               d.format = INSTR_FORMAT_J;
            default:                                                  d.format = INSTR_FORMAT_OTHER;
        endcase
        // Sign-extended immediate by format
        case (d.format)
            INSTR_FORMAT_I: d.imm = {{20{instr[31]}}, instr[31:20]};
            INSTR_FORMAT_S: d.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            INSTR_FORMAT_B: d.imm = {{19{instr[31]}}, instr[31], instr[7],
                                     instr[30:25], instr[11:8], 1'b0};
            INSTR_FORMAT_U: d.imm = {instr[31:12], 12'b0};
            INSTR_FORMAT_J: d.imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                     instr[20], instr[30:21], 1'b0};
            default:        d.imm = '0;
        endcase
        // Bit 30 only selects SUB for register forms
        d.alu_op = ALU_ADD;
        if (opc == OPCODE_OP || opc == OPCODE_OP_IMM) begin
            case (funct3)
                3'b000:  d.alu_op = (opc == OPCODE_OP && instr[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  d.alu_op = ALU_SLL;
                3'b010:  d.alu_op = ALU_SLT;
                3'b100:  d.alu_op = ALU_XOR;
                3'b101:  d.alu_op = ALU_SRL;
                3'b110:  d.alu_op = ALU_OR;
                3'b111:  d.alu_op = ALU_AND;
                default: d.alu_op = ALU_ADD;
            endcase
        end
        // Only register-register ops take rs2 into the ALU
        d.use_imm = (opc != OPCODE_OP);
        if (!d.illegal) begin
            d.is_load  = (opc == OPCODE_LOAD);
            d.is_store = (opc == OPCODE_STORE);
            d.is_halt  = (opc == OPCODE_CUSTOM_0);
            d.rd_we    = (opc inside {OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_LOAD})
                         && (d.rd_idx != '0);
        end
        return d;
    endfunction

    // Incoming word steers acceptance while the latched word drives execution
    assign dec_in = decode_word(instruction);
    assign dec    = decode_word(instr_q);
    assign accept = ready && instr_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= INIT;
        end else begin
            state_q <= state_d;
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instruction;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            INIT:       state_d = FETCH_NEXT;
            HALT:       state_d = HALT;
            FETCH_NEXT: begin
                if (accept) begin
                    if (dec_in.is_halt) begin
                        state_d = HALT;
                    end else if (dec_in.is_load || dec_in.is_store) begin
                        state_d = WAIT_ON_L1DCACHE;
                    end else begin
                        state_d = FINISH_CURRENT_AND_FETCH_NEXT;
                    end
                end
            end
            WAIT_ON_L1DCACHE: begin
                if (timer_done) begin
                    state_d = FINISH_CURRENT_AND_FETCH_NEXT;
                end
            end
            FINISH_CURRENT_AND_FETCH_NEXT: state_d = FETCH_NEXT;
            // Corrupted state stops the stage for good
            default:    state_d = HALT;
        endcase
    end

    assign ready  = (state_q == FETCH_NEXT);
    assign retire = (state_q == FINISH_CURRENT_AND_FETCH_NEXT);
    assign halted = (state_q == HALT);

    // Operand routing
    assign rs1_idx = dec.rs1_idx;
    assign rs2_idx = dec.rs2_idx;
    assign alu_op  = dec.alu_op;
    assign alu_b   = dec.use_imm ? dec.imm : rs2_data;

    // Memory address is rs1 plus offset from the ALU
    assign timer_start = accept && (dec_in.is_load || dec_in.is_store);
    assign dmem_addr   = alu_result;
    assign dmem_wdata  = rs2_data;
    assign dmem_we     = (state_q == WAIT_ON_L1DCACHE) && timer_done && dec.is_store;

    // Write-back enables only live during retire
    assign wb.rd_idx  = dec.rd_idx;
    assign wb.value   = (dec.format == INSTR_FORMAT_U) ? dec.imm :
                        dec.is_load                   ? dmem_rdata : alu_result;
    assign wb.rd_we   = retire && dec.rd_we;
    assign wb.illegal = retire && dec.illegal;

    // Timer only finishes while control waits on it
    assert property (@(posedge clk) disable iff (!rst_n)
        timer_done |-> (state_q == WAIT_ON_L1DCACHE))
        else $error("memory timer done outside the memory wait");

    assert property (@(posedge clk) disable iff (!rst_n)
        state_q inside {INIT, HALT, FETCH_NEXT, WAIT_ON_L1DCACHE,
                        FINISH_CURRENT_AND_FETCH_NEXT})
        else $error("control FSM in an illegal state");

endmodule : core_s2_control

`default_nettype wire

//--- logic/core_dmem.sv
// --------------------------------------------------
// Word-addressed data RAM with registered read
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_dmem #(
    parameter int DMEM_DEPTH = 64
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire core_pkg::word_t addr,
    input  wire core_pkg::word_t wdata,
    input  wire logic            we,
    output core_pkg::word_t      rdata
);

    import core_pkg::*;

    localparam int IDX_W = (DMEM_DEPTH > 1) ? $clog2(DMEM_DEPTH) : 1;

    word_t            mem [DMEM_DEPTH];
    logic [IDX_W-1:0] idx;

    // Word index from the byte address, wrapping at the depth
    assign idx = IDX_W'(addr[31:2] % DMEM_DEPTH);

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    // Read every cycle so data is ready when the wait ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else begin
            rdata <= mem[idx];
        end
    end

    // Only full-word stores exist
    assert property (@(posedge clk) disable iff (!rst_n) we |-> (addr[1:0] == 2'b00))
        else $error("misaligned store address %h", addr);

endmodule : core_dmem

`default_nettype wire

//--- logic/core_dmem_wait_timer.sv
// --------------------------------------------------
// Data memory wait timer, counts the fixed latency
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_dmem_wait_timer #(
    parameter int DMEM_LATENCY = 3
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic start,
    output logic      done
);

    // Wide enough to hold the full latency
    localparam int CNT_W = $clog2(DMEM_LATENCY + 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (start) begin
            count_q <= CNT_W'(DMEM_LATENCY);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Last cycle of the wait
    assign done = (count_q == CNT_W'(1));

    // Control must not restart a running access
    assert property (@(posedge clk) disable iff (!rst_n) start |-> (count_q == '0))
        else $error("timer started while still counting");

endmodule : core_dmem_wait_timer

`default_nettype wire

//--- logic/core_regfile.sv
// --------------------------------------------------
// Register file, 2 read ports and 1 write port
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_regfile (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire core_pkg::reg_idx_t rs1_idx,
    input  wire core_pkg::reg_idx_t rs2_idx,
    output core_pkg::word_t         rs1_data,
    output core_pkg::word_t         rs2_data,
    input  wire core_pkg::wb_t      wb
);

    import core_pkg::*;

    // x1 to x31 only, x0 has no storage
    word_t regs [1:31];

    // Write on retire, x0 writes dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.rd_we && (wb.rd_idx != '0)) begin
            regs[wb.rd_idx] <= wb.value;
        end
    end

    // Asynchronous reads, x0 reads as zero
    always_comb begin
        if (rs1_idx == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_idx];
        end
        if (rs2_idx == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_idx];
        end
    end

endmodule : core_regfile

`default_nettype wire

//--- logic/core_alu.sv
// --------------------------------------------------
// Combinational ALU for the supported RV32I ops
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_alu (
    input  wire core_pkg::word_t   a,
    input  wire core_pkg::word_t   b,
    input  wire core_pkg::alu_op_e op,
    output core_pkg::word_t        result
);

    import core_pkg::*;

    logic [4:0] shamt;

    // Shift amount is the low 5 bits of the second operand
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            // Logical right shift, zero fill
            ALU_SRL: begin
                result = a >> shamt;
            end
            // Signed compare, result is 0 or 1
            ALU_SLT: begin
                result = {31'b0, ($signed(a) < $signed(b))};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule : core_alu

`default_nettype wire

//--- logic/core_pkg.sv
// --------------------------------------------------
// Core shared types: opcodes, formats, ALU operations,
// decode and write-back records
// --------------------------------------------------

`default_nettype none

package core_pkg;

    // Basic data types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // RV32 major opcodes, instruction bits 6 to 2
    typedef enum logic [4:0] {
        OPCODE_LOAD     = 5'b00000,
        OPCODE_CUSTOM_0 = 5'b00010,
        OPCODE_MISC_MEM = 5'b00011,
        OPCODE_OP_IMM   = 5'b00100,
        OPCODE_AUIPC    = 5'b00101,
        OPCODE_STORE    = 5'b01000,
        OPCODE_AMO      = 5'b01011,
        OPCODE_OP       = 5'b01100,
        OPCODE_LUI      = 5'b01101,
        OPCODE_BRANCH   = 5'b11000,
        OPCODE_JALR     = 5'b11001,
        OPCODE_JAL      = 5'b11011,
        OPCODE_SYSTEM   = 5'b11100
    } opcode_e;

    // Instruction encoding formats
    typedef enum logic [2:0] {
        INSTR_FORMAT_R,
        INSTR_FORMAT_I,
        INSTR_FORMAT_S,
        INSTR_FORMAT_B,
        INSTR_FORMAT_U,
        INSTR_FORMAT_J,
        INSTR_FORMAT_OTHER
    } instr_format_e;

    // ALU operations, exactly eight so three bits cover them
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

    // Everything the stage needs from one decoded instruction
    typedef struct packed {
        instr_format_e format;
        alu_op_e       alu_op;
        reg_idx_t      rd_idx;
        reg_idx_t      rs1_idx;
        reg_idx_t      rs2_idx;
        word_t         imm;
        logic          use_imm;
        logic          rd_we;
        logic          is_load;
        logic          is_store;
        logic          is_halt;
        logic          illegal;
    } decode_t;

    // Retire record, also the register file write port
    typedef struct packed {
        reg_idx_t rd_idx;
        word_t    value;
        logic     rd_we;
        logic     illegal;
    } wb_t;

endpackage : core_pkg

`default_nettype wire
